/* Makefile */
# Verilator build and run for the game frame testbench

VERILATOR ?= verilator
TOP       ?= tb_game
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "No result in log"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
+incdir+.
game_pkg.sv
cen_gen.sv
video_timer.sv
rom_dwnld.sv
rom_slot_arb.sv
game_top.sv
tb_game.sv

/* cen_gen.sv */
//////////////////////////////////////////////////////////////////////
// Clock enable generator
// Divides the 48 MHz system clock into 12, 6 and 3 MHz enable pulses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cen_gen (
    input  logic clk,
    input  logic rst,
    output logic cen12,
    output logic cen6,
    output logic cen3
);

    logic [3:0] div;

    // Free-running divider
    always_ff @(posedge clk) begin
        if (rst) begin
            div <= '0;
        end else begin
            div <= div + 4'd1;
        end
    end

    // One cycle per all-ones state of the low bits
    assign cen12 = &div[1:0];   // Every 4 cycles
    assign cen6  = &div[2:0];   // Every 8 cycles
    assign cen3  = &div;        // Every 16 cycles

    // Slower enables must land on a faster one
    a_cen_nested: assert property (
        @(posedge clk) disable iff (rst)
        cen3 |-> (cen6 && cen12)
    );

endmodule

/* game_defs.svh */
//////////////////////////////////////////////////////////////////////
// Game frame constants
// Raster geometry, blanking and sync windows, ROM slot layout and
// the byte address where PROM data starts in the download stream
//////////////////////////////////////////////////////////////////////

`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// Raster size, counted in 6 MHz pixels and lines
`define H_TOTAL      384
`define V_TOTAL      262

`define H_VIS_END    256   // First blanked column
`define V_VIS_START  16
`define V_VIS_END    240

// Sync windows
`define HS_START     304
`define HS_END       336
`define VS_START     248
`define VS_END       252

// ROM slots sharing the SDRAM read port
`define ROM_SLOTS    4
`define SLOT0_OFFSET 22'h00_0000   // Word offsets
`define SLOT1_OFFSET 22'h00_0400
`define SLOT2_OFFSET 22'h00_0800
`define SLOT3_OFFSET 22'h00_0C00

`define PROM_START   25'h000_2000  // Byte address, start of PROMs

`endif

/* game_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Game frame types
// Vector widths, ROM slot request/response structs, the download
// write struct and the slot arbiter states
//////////////////////////////////////////////////////////////////////

package game_pkg;

    typedef logic [8:0]  raster_t;       // H or V count
    typedef logic [21:0] sdram_addr_t;   // 16-bit word address
    typedef logic [15:0] sdram_data_t;
    typedef logic [24:0] ioctl_addr_t;   // Byte address of download
    typedef logic [7:0]  byte_t;

    // One ROM slot request from a game block
    typedef struct packed {
        logic        cs;
        sdram_addr_t addr;
    } rom_req_t;

    // Slot answer, data valid while ok is high
    typedef struct packed {
        logic        ok;
        sdram_data_t data;
    } rom_rsp_t;

    // SDRAM write built from the download stream
    typedef struct packed {
        sdram_addr_t addr;
        byte_t       data;
        logic [1:0]  mask;   // Active low, bit 0 is the low byte lane
    } prog_wr_t;

    // Slot arbiter FSM
    typedef enum logic [1:0] {
        idle      = 2'd0,
        request   = 2'd1,
        wait_data = 2'd2
    } arb_state_t;

endpackage

/* game_top.sv */
//////////////////////////////////////////////////////////////////////
// Arcade game frame top level
// Clock enables, raster timing, ROM download and ROM slot sharing
// around the game specific CPU and video blocks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "game_defs.svh"

module game_top import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // ROM slots
    input  rom_req_t    slot_req [`ROM_SLOTS],
    output rom_rsp_t    slot_rsp [`ROM_SLOTS],
    // SDRAM read port
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  sdram_data_t data_read,
    // ROM download
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  byte_t       ioctl_dout,
    input  logic        ioctl_wr,
    output prog_wr_t    prog,
    output logic        prog_we,
    output logic [8:0]  prom_we,
    output logic [6:0]  prom_addr,
    // Video timing
    output logic        pxl2_cen,   // 12 MHz
    output logic        pxl_cen,    // 6 MHz
    output raster_t     h,
    output raster_t     v,
    output logic        lhbl,
    output logic        lvbl,
    output logic        hs,
    output logic        vs
);

    cen_gen u_cen (
        .clk   ( clk      ),
        .rst   ( rst      ),
        .cen12 ( pxl2_cen ),
        .cen6  ( pxl_cen  ),
        .cen3  (          )   // For the game CPU
    );

    video_timer u_timer (
        .clk  ( clk     ),
        .rst  ( rst     ),
        .cen6 ( pxl_cen ),
        .h    ( h       ),
        .v    ( v       ),
        .lhbl ( lhbl    ),
        .lvbl ( lvbl    ),
        .hs   ( hs      ),
        .vs   ( vs      )
    );

    // Shares sdram_ack with the read port, no overlap while downloading
    rom_dwnld u_dwnld (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog        ( prog        ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     ),
        .prom_addr   ( prom_addr   )
    );

    rom_slot_arb u_rom (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .slot_req    ( slot_req    ),
        .slot_rsp    ( slot_rsp    ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   )
    );

endmodule

/* game_trace.txt */
// Columns: op(1) slot(1) address(6) data(4), all hex
// op 1 download byte, 2 queue slot read, 3 run reads, 4 enables, 5 frame, 6 downloading
400000000000
600000000001
100000200034
100000210012
1000080A00CD
1000080B00AB
10001140000F
1000114100BE
10001FFE0077
10001FFF0066
1000200000A1
10002385005B
1000240500C7
600000000000
200000101234
300000000000
21000005ABCD
300000000000
220000A0BE0F
230003FF6677
300000000000
500000000000

/* rom_dwnld.sv */
//////////////////////////////////////////////////////////////////////
// ROM download splitter
// Bytes below the PROM boundary become masked SDRAM writes held until
// acknowledged; bytes above it pulse one of nine PROM write strobes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "game_defs.svh"

module rom_dwnld import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  byte_t       ioctl_dout,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    output prog_wr_t    prog,
    output logic        prog_we,
    output logic [8:0]  prom_we,
    output logic [6:0]  prom_addr
);

    logic       wr_in;
    logic       is_prom;
    logic [8:0] prom_dec;

    assign wr_in   = ioctl_wr && downloading;
    assign is_prom = ioctl_addr >= `PROM_START;

    // One-hot PROM select, codes above 8 select nothing
    always_comb begin
        for (int i = 0; i < 9; i++) begin
            prom_dec[i] = ioctl_addr[10:7] == 4'(i);
        end
    end

    // Write request level, released after the ack
    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
            prom_we <= '0;
        end else begin
            if (sdram_ack) prog_we <= 1'b0;
            if (wr_in && !is_prom) prog_we <= 1'b1;
            prom_we <= (wr_in && is_prom) ? prom_dec : 9'd0;   // Single pulse
        end
    end

    always_ff @(posedge clk) begin
        if (wr_in) begin
            prog.addr <= ioctl_addr[22:1];
            prog.data <= ioctl_dout;
            prog.mask <= ioctl_addr[0] ? 2'b01 : 2'b10;   // Odd byte -> high lane
            prom_addr <= ioctl_addr[6:0];
        end
    end

    a_mask_lane: assert property (
        @(posedge clk) disable iff (rst)
        prog_we |-> (prog.mask != 2'b11)
    );

endmodule

/* rom_slot_arb.sv */
//////////////////////////////////////////////////////////////////////
// ROM slot arbiter
// Four ROM slots with a one-word cache each; misses are served in
// fixed priority through the shared SDRAM read port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "game_defs.svh"

module rom_slot_arb import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    input  rom_req_t    slot_req [`ROM_SLOTS],
    output rom_rsp_t    slot_rsp [`ROM_SLOTS],
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  sdram_data_t data_read
);

    localparam int SLOT_W = $clog2(`ROM_SLOTS);

    localparam sdram_addr_t SLOT_OFFSET [`ROM_SLOTS] = '{
        `SLOT0_OFFSET, `SLOT1_OFFSET, `SLOT2_OFFSET, `SLOT3_OFFSET
    };

    arb_state_t            state;
    logic [`ROM_SLOTS-1:0] cache_vld;
    sdram_addr_t           cache_addr [`ROM_SLOTS];   // Slot-relative address
    sdram_data_t           cache_data [`ROM_SLOTS];
    logic [`ROM_SLOTS-1:0] hit;
    logic [`ROM_SLOTS-1:0] miss;
    logic [SLOT_W-1:0]     pick;
    logic                  any_miss;
    logic [SLOT_W-1:0]     fetch_slot;
    sdram_addr_t           fetch_addr;

    // Hit and miss per slot
    always_comb begin
        for (int i = 0; i < `ROM_SLOTS; i++) begin
            hit[i]  = cache_vld[i] && (cache_addr[i] == slot_req[i].addr);
            miss[i] = slot_req[i].cs && !hit[i];
            slot_rsp[i].ok   = slot_req[i].cs && hit[i] && !downloading;
            slot_rsp[i].data = cache_data[i];
        end
    end

    // Lowest numbered miss wins
    always_comb begin
        pick     = '0;
        any_miss = 1'b0;
        for (int i = `ROM_SLOTS - 1; i >= 0; i--) begin
            if (miss[i]) begin
                pick     = SLOT_W'(i);
                any_miss = 1'b1;
            end
        end
    end

    assign sdram_req = (state == request) && !downloading;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            cache_vld <= '0;
        end else if (downloading) begin
            state     <= idle;   // ROM contents are changing
            cache_vld <= '0;
        end else begin
            case (state)
                idle: begin
                    if (any_miss) state <= request;
                end
                request: begin
                    if (sdram_ack) state <= wait_data;
                end
                wait_data: begin
                    if (data_rdy) begin
                        cache_vld[fetch_slot] <= 1'b1;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Fetch bookkeeping and cached words
    always_ff @(posedge clk) begin
        if (state == idle && any_miss) begin
            fetch_slot <= pick;
            fetch_addr <= slot_req[pick].addr;
            sdram_addr <= SLOT_OFFSET[pick] + slot_req[pick].addr;
        end
        if (state == wait_data && data_rdy) begin
            cache_addr[fetch_slot] <= fetch_addr;   // Address at pick time
            cache_data[fetch_slot] <= data_read;
        end
    end

    // Request held with a stable address until the controller takes it
    a_req_hold: assert property (
        @(posedge clk) disable iff (rst || downloading)
        (sdram_req && !sdram_ack) |=> (sdram_req && $stable(sdram_addr))
    );

endmodule

/* tb_game.sv */
//////////////////////////////////////////////////////////////////////
// Game frame testbench
// Replays the trace against game_top with an SDRAM model, checks
// download writes, PROM strobes, slot reads and raster timing
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "game_defs.svh"

module tb_game import game_pkg::*; ();

    logic        clk, rst;
    rom_req_t    slot_req [`ROM_SLOTS];
    rom_rsp_t    slot_rsp [`ROM_SLOTS];
    logic        sdram_req, sdram_ack, data_rdy;
    sdram_addr_t sdram_addr;
    sdram_data_t data_read;
    logic        downloading, ioctl_wr, prog_we;
    ioctl_addr_t ioctl_addr;
    byte_t       ioctl_dout;
    prog_wr_t    prog;
    logic [8:0]  prom_we;
    logic [6:0]  prom_addr;
    logic        pxl2_cen, pxl_cen, lhbl, lvbl, hs, vs;
    raster_t     h, v;

    logic [47:0] trace [0:63];   // op, slot, address, data
    sdram_data_t sdram_mem [0:8191];
    logic [31:0] lfsr_state = 32'd90331;
    int          n_entries, err_count, test_count, ack_cnt, req_cycles;
    int          q_slot [$];
    sdram_addr_t q_addr [$];
    sdram_data_t q_exp [$];

    game_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic lfsr_step();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) lfsr_state = lfsr_state ^ 32'hD000_0001;
        return lsb;
    endfunction

    task automatic check_prog(string what, prog_wr_t got, prog_wr_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_word(string what, sdram_data_t got, sdram_data_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_raster(string what, raster_t got, raster_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_count(string what, int got, int exp);
        if (got != exp) begin
            $display("** Error at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    // Handshake monitors, sampled where inputs are stable
    always @(posedge clk) begin
        if (sdram_ack && prog_we) ack_cnt++;
        if (sdram_req) req_cycles++;
    end

    // SDRAM model, ack after 1 to 4 cycles and data 2 cycles later
    initial begin
        int          delay;
        prog_wr_t    w;
        sdram_addr_t a;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        for (int i = 0; i < 8192; i++) sdram_mem[i] = 16'(i * 40503) ^ 16'(i >> 5);
        forever begin
            @(negedge clk);
            if (!rst && (prog_we || sdram_req)) begin
                delay = 1;
                if (lfsr_step()) delay += 1;
                if (lfsr_step()) delay += 2;
                repeat (delay - 1) @(negedge clk);
                sdram_ack = 1'b1;
                if (prog_we) begin
                    w = prog;
                    if (!w.mask[0]) sdram_mem[w.addr[12:0]][7:0]  = w.data;
                    if (!w.mask[1]) sdram_mem[w.addr[12:0]][15:8] = w.data;
                    @(negedge clk) sdram_ack = 1'b0;
                end else begin
                    a = sdram_addr;
                    @(negedge clk) sdram_ack = 1'b0;
                    @(negedge clk);
                    data_read = sdram_mem[a[12:0]];
                    data_rdy  = 1'b1;
                    @(negedge clk) data_rdy = 1'b0;
                end
            end
        end
    end

    task automatic test_cen();
        int n12, n6, bad;
        n12 = 0;
        n6  = 0;
        bad = 0;
        repeat (64) begin
            @(negedge clk);
            n12 += pxl2_cen;
            n6  += pxl_cen;
            if (pxl_cen && !pxl2_cen) bad++;
        end
        check_count("pxl2_cen pulses", n12, 16);
        check_count("pxl_cen pulses", n6, 8);
        check_count("pxl_cen without pxl2_cen", bad, 0);
    endtask

    task automatic download_byte(ioctl_addr_t a, byte_t d);
        int       waited, acks;
        prog_wr_t exp;
        @(negedge clk);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        acks = ack_cnt;
        @(negedge clk) ioctl_wr = 1'b0;
        if (a >= 25'h2000) begin
            check_count("prom_we strobe", int'(prom_we), 1 << a[10:7]);
            check_count("prom_addr", int'(prom_addr), int'(a[6:0]));
            check_count("prog_we on PROM byte", int'(prog_we), 0);
            @(negedge clk);
            check_count("prom_we after pulse", int'(prom_we), 0);
        end else begin
            exp.addr = sdram_addr_t'(a >> 1);   // Two bytes per word
            exp.data = d;
            exp.mask = (a % 2 == 0) ? 2'b10 : 2'b01;
            check_prog("prog write", prog, exp);
            check_count("prog_we raised", int'(prog_we), 1);
            waited = 0;
            while (prog_we && waited < 50) begin
                @(negedge clk);
                waited++;
            end
            if (prog_we) begin
                $display("prog_we was never released at %0t", $time);
                err_count++;
            end
            check_count("acks while prog_we held", ack_cnt - acks, 1);
        end
    endtask

    task automatic run_slots();
        int waited, all_ok, req0;
        @(negedge clk);
        foreach (q_slot[i]) slot_req[q_slot[i]] = '{cs: 1'b1, addr: q_addr[i]};
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            all_ok = 1;
            foreach (q_slot[i]) if (!slot_rsp[q_slot[i]].ok) all_ok = 0;
        end while (!all_ok && waited < 200);
        if (!all_ok) begin
            $display("Slot read got no ok within 200 cycles at %0t", $time);
            err_count++;
        end
        foreach (q_slot[i]) check_word("slot data", slot_rsp[q_slot[i]].data, q_exp[i]);
        foreach (q_slot[i]) slot_req[q_slot[i]].cs = 1'b0;
        @(negedge clk);
        foreach (q_slot[i]) slot_req[q_slot[i]].cs = 1'b1;   // Repeat read
        req0 = req_cycles;
        @(negedge clk);
        foreach (q_slot[i]) check_count("repeat read ok", int'(slot_rsp[q_slot[i]].ok), 1);
        foreach (q_slot[i]) check_word("repeat data", slot_rsp[q_slot[i]].data, q_exp[i]);
        repeat (6) @(negedge clk);
        check_count("new sdram_req on repeat", req_cycles - req0, 0);
        foreach (q_slot[i]) slot_req[q_slot[i]].cs = 1'b0;
        q_slot.delete();
        q_addr.delete();
        q_exp.delete();
    endtask

    task automatic test_frame();
        int      nh, nv, nhs, nvs, started, errs_pos;
        raster_t eh, ev;
        nh = 0;
        nv = 0;
        nhs = 0;
        nvs = 0;
        started = 0;
        eh = '0;
        ev = '0;
        errs_pos = err_count;
        repeat (384 * 262) begin
            do @(negedge clk); while (!pxl_cen);
            if (!started) begin
                eh = h;
                ev = v;
                started = 1;
            end else if (eh == 9'd383) begin   // End of line
                eh = '0;
                ev = (ev == 9'd261) ? 9'd0 : ev + 9'd1;
            end else begin
                eh = eh + 9'd1;
            end
            // Report the first position mismatch only
            if (err_count == errs_pos) begin
                check_raster("h position", h, eh);
                check_raster("v position", v, ev);
            end
            nh += lhbl;
            nv += lvbl;
            nhs += hs;
            nvs += vs;
        end
        check_count("lhbl pixels per frame", nh, 256 * 262);
        check_count("lvbl pixels per frame", nv, 224 * 384);
        check_count("hs pixels per frame", nhs, 32 * 262);
        check_count("vs pixels per frame", nvs, 4 * 384);
    endtask

    // Watchdog, twenty cycles per trace line plus two frames
    initial begin
        #1;
        repeat (n_entries * 20 + 2 * 384 * 262 * 8) @(posedge clk);
        $display("Timeout: the run did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int  errs0;
        string name;
        rst = 1'b1;
        downloading = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        for (int i = 0; i < `ROM_SLOTS; i++) slot_req[i] = '0;
        for (int i = 0; i < 64; i++) trace[i] = '1;
        $readmemh("game_trace.txt", trace);
        n_entries = 0;
        while (n_entries < 64 && trace[n_entries][47:44] != 4'hF) n_entries++;
        repeat (2) @(posedge clk);
        @(negedge clk) rst = 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            errs0 = err_count;
            case (trace[i][47:44])
                4'h1: begin
                    download_byte(ioctl_addr_t'(trace[i][39:16]), trace[i][7:0]);
                    name = "download byte";
                end
                4'h2: begin
                    q_slot.push_back(int'(trace[i][43:40]));
                    q_addr.push_back(sdram_addr_t'(trace[i][39:16]));
                    q_exp.push_back(trace[i][15:0]);
                    name = "queue slot read";
                end
                4'h3: begin
                    run_slots();
                    name = "slot reads";
                end
                4'h4: begin
                    test_cen();
                    name = "clock enables";
                end
                4'h5: begin
                    test_frame();
                    name = "raster frame";
                end
                4'h6: begin
                    @(negedge clk) downloading = trace[i][0];
                    name = "downloading level";
                end
                default: name = "unknown op";
            endcase
            test_count++;
            $display("test %0d %s: %s", i, name, (err_count == errs0) ? "ok" : "failed");
        end
        $display("%0d tests run, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* video_timer.sv */
//////////////////////////////////////////////////////////////////////
// Video raster timer
// H and V counters stepped by the pixel enable, with registered
// blanking and sync outputs decoded from the raster constants
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "game_defs.svh"

module video_timer import game_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cen6,
    output raster_t h,
    output raster_t v,
    output logic    lhbl,
    output logic    lvbl,
    output logic    hs,
    output logic    vs
);

    raster_t h_nxt;
    raster_t v_nxt;

    // Next raster position
    always_comb begin
        h_nxt = h + raster_t'(1);
        v_nxt = v;
        if (h == raster_t'(`H_TOTAL - 1)) begin
            h_nxt = '0;
            if (v == raster_t'(`V_TOTAL - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = v + raster_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            h    <= '0;
            v    <= '0;
            lhbl <= 1'b1;   // Column 0 is visible
            lvbl <= 1'b0;   // Line 0 is in the top border
            hs   <= 1'b0;
            vs   <= 1'b0;
        end else if (cen6) begin
            h    <= h_nxt;
            v    <= v_nxt;
            // Decoded from the next count so outputs track h and v
            lhbl <= h_nxt < raster_t'(`H_VIS_END);
            lvbl <= (v_nxt >= raster_t'(`V_VIS_START)) &&
                    (v_nxt <  raster_t'(`V_VIS_END));
            hs   <= (h_nxt >= raster_t'(`HS_START)) &&
                    (h_nxt <  raster_t'(`HS_END));
            vs   <= (v_nxt >= raster_t'(`VS_START)) &&
                    (v_nxt <  raster_t'(`VS_END));
        end
    end

    a_h_range: assert property (
        @(posedge clk) disable iff (rst)
        h < raster_t'(`H_TOTAL)
    );

endmodule
